// ==== tile_net_top.f ====
+incdir+include
src/tile_net_pkg.sv
src/return_if.sv
src/eva_to_npa.sv
src/network_tx.sv
src/return_fifo.sv
src/out_credit_counter.sv
src/tile_net_top.sv
bench/tile_net_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tile network endpoint testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tile_net_top.f \
  --top-module tile_net_tb \
  --Mdir "$BUILD_DIR" -o tile_net_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tile_net_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== bench/tile_net_tb.sv ====
/*
 * Tile network endpoint testbench
 * Table-driven requests and returns against the endpoint top level,
 * checking packet fields, credits and return steering.
 */

`timescale 1ns/1ps

`include "tile_net_defs.svh"

module tile_net_tb;

  localparam int TIMEOUT = 40;
  localparam int N_REQ = 10;
  localparam int N_RET = 7;
  localparam int SEL_REQ_READY = 0;
  localparam int SEL_RET_READY = 1;
  localparam int SEL_IFETCH = 2;
  localparam int SEL_INT = 3;
  localparam int SEL_FLOAT = 4;

  // kind is 0 load, 1 store, 2 amo
  typedef struct packed {
    tile_net_pkg::eva_t eva;
    logic [1:0] kind;
    tile_net_pkg::data_t data;
    logic [3:0] mask;
    tile_net_pkg::reg_id_t rid;
    logic dram;
    tile_net_pkg::x_cord_t x;
    tile_net_pkg::y_cord_t y;
    tile_net_pkg::npa_addr_t addr;
    logic inv;
  } req_row_t;

  typedef struct packed {
    tile_net_pkg::ret_type_e rtype;
    tile_net_pkg::reg_id_t rid;
    tile_net_pkg::data_t data;
    logic yumi;
  } ret_row_t;

  logic clk_i;
  logic rst_n_i;
  tile_net_pkg::x_cord_t my_x_i;
  tile_net_pkg::y_cord_t my_y_i;
  tile_net_pkg::x_cord_t tgo_x_i;
  tile_net_pkg::y_cord_t tgo_y_i;
  logic dram_enable_i;
  tile_net_pkg::remote_req_t req_i;
  logic req_v_i;
  logic req_ready_o;
  tile_net_pkg::net_packet_t pkt_o;
  logic pkt_v_o;
  logic invalid_eva_o;
  logic ret_v_i;
  tile_net_pkg::ret_type_e ret_type_i;
  tile_net_pkg::reg_id_t ret_reg_id_i;
  tile_net_pkg::data_t ret_data_i;
  logic ret_ready_o;
  logic ifetch_v_o;
  tile_net_pkg::data_t ifetch_instr_o;
  logic int_v_o;
  tile_net_pkg::reg_id_t int_rd_o;
  tile_net_pkg::data_t int_data_o;
  logic int_force_o;
  logic int_yumi_i;
  logic float_v_o;
  tile_net_pkg::reg_id_t float_rd_o;
  tile_net_pkg::data_t float_data_o;
  logic float_force_o;
  logic float_yumi_i;
  tile_net_pkg::credit_cnt_t credits_o;

  req_row_t req_tab [N_REQ];
  ret_row_t ret_tab [N_RET];
  integer seed;
  int errors;
  int checks;
  int test_err;
  int i;
  logic hung;

  tile_net_top i_tile_net_top (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge hung) begin
    $display("** FAIL **");
    $finish;
  end

  task automatic fill_tables();
    // this tile sits at (1,2); expected x, y and address follow the address map
    req_tab[0] = '{32'h0000_0124, 2'd0, 32'h0, 4'hf, 5'd7, 1'b0, 4'd1, 4'd2, 16'h0049, 1'b0};
    req_tab[1] = '{32'h0003_fffc, 2'd1, 32'hdead_beef, 4'h3, 5'd1, 1'b0, 4'd1, 4'd2, 16'hffff, 1'b0};
    req_tab[2] = '{32'h4c80_0040, 2'd2, 32'h0000_1234, 4'h6, 5'd9, 1'b0, 4'd3, 4'd2, 16'h0010, 1'b0};
    req_tab[3] = '{32'h4440_0008, 2'd0, 32'h0, 4'hf, 5'd31, 1'b0, 4'd1, 4'd1, 16'h0002, 1'b0};
    req_tab[4] = '{32'h8000_100c, 2'd1, 32'hcafe_f00d, 4'hc, 5'd2, 1'b1, 4'd3, 4'd4, 16'h0403, 1'b0};
    req_tab[5] = '{32'h8001_0004, 2'd2, 32'h0bad_cafe, 4'h9, 5'd12, 1'b1, 4'd1, 4'd4, 16'h4001, 1'b0};
    // dram disabled, global x out of range, global y out of range, local high bits
    req_tab[6] = '{32'h8000_0010, 2'd0, 32'h0, 4'hf, 5'd3, 1'b0, 4'd0, 4'd0, 16'h0, 1'b1};
    req_tab[7] = '{32'h5400_0000, 2'd1, 32'h5555_aaaa, 4'hf, 5'd4, 1'b0, 4'd0, 4'd0, 16'h0, 1'b1};
    req_tab[8] = '{32'h4100_0000, 2'd0, 32'h0, 4'hf, 5'd5, 1'b0, 4'd0, 4'd0, 16'h0, 1'b1};
    req_tab[9] = '{32'h0004_0000, 2'd2, 32'h1111_2222, 4'h1, 5'd6, 1'b0, 4'd0, 4'd0, 16'h0, 1'b1};
    // rows 3 to 6 fill the buffer and row 3 gets popped by force
    ret_tab[0] = '{tile_net_pkg::e_ret_int_wb, 5'd3, $random(seed), 1'b1};
    ret_tab[1] = '{tile_net_pkg::e_ret_float_wb, 5'd17, $random(seed), 1'b1};
    ret_tab[2] = '{tile_net_pkg::e_ret_ifetch, 5'd0, $random(seed), 1'b0};
    ret_tab[3] = '{tile_net_pkg::e_ret_int_wb, 5'd8, $random(seed), 1'b0};
    ret_tab[4] = '{tile_net_pkg::e_ret_float_wb, 5'd21, $random(seed), 1'b1};
    ret_tab[5] = '{tile_net_pkg::e_ret_ifetch, 5'd0, $random(seed), 1'b0};
    ret_tab[6] = '{tile_net_pkg::e_ret_int_wb, 5'd30, $random(seed), 1'b1};
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      SEL_REQ_READY: return req_ready_o;
      SEL_RET_READY: return ret_ready_o;
      SEL_IFETCH: return ifetch_v_o;
      SEL_INT: return int_v_o;
      default: return float_v_o;
    endcase
  endfunction

  // called on a falling edge, returns a quarter cycle later once the signal is high
  task automatic wait_for(input int sel, input string what);
    int n;
    n = 0;
    #5;
    while (!probe(sel) && n < TIMEOUT) begin
      @(negedge clk_i);
      #5;
      n++;
    end
    if (!probe(sel)) begin
      $display("timeout: %s stayed low for %0d cycles, t=%0t", what, TIMEOUT, $time);
      errors++;
      hung = 1'b1;
    end
  endtask

  task automatic drive_req(input req_row_t q);
    dram_enable_i = q.dram;
    req_i.addr = q.eva;
    req_i.data = q.data;
    req_i.mask = q.mask;
    req_i.reg_id = q.rid;
    req_i.write_not_read = (q.kind == 2'd1);
    req_i.is_amo = (q.kind == 2'd2);
    req_i.amo_type = ~q.mask;
    req_v_i = 1'b1;
  endtask

  task automatic check_packet(input req_row_t q);
    tile_net_pkg::net_op_e exp_op;
    logic [3:0] exp_op_ex;
    tile_net_pkg::data_t exp_payload;
    if (q.kind == 2'd2) begin
      exp_op = tile_net_pkg::e_remote_amo;
    end else if (q.kind == 2'd1) begin
      exp_op = tile_net_pkg::e_remote_store;
    end else begin
      exp_op = tile_net_pkg::e_remote_load;
    end
    exp_op_ex = (q.kind == 2'd2) ? ~q.mask : q.mask;
    // loads carry only the register id
    exp_payload = (q.kind == 2'd0) ? 32'(q.rid) : q.data;
    check_val("invalid_eva_o", 32'(q.inv), 32'(invalid_eva_o));
    check_val("pkt_v_o", 32'(!q.inv), 32'(pkt_v_o));
    if (!q.inv) begin
      check_val("pkt_o.dest_x", 32'(q.x), 32'(pkt_o.dest_x));
      check_val("pkt_o.dest_y", 32'(q.y), 32'(pkt_o.dest_y));
      check_val("pkt_o.addr", 32'(q.addr), 32'(pkt_o.addr));
      check_val("pkt_o.op", 32'(exp_op), 32'(pkt_o.op));
      check_val("pkt_o.op_ex", 32'(exp_op_ex), 32'(pkt_o.op_ex));
      check_val("pkt_o.payload", exp_payload, pkt_o.payload);
      check_val("pkt_o.reg_id", 32'(q.rid), 32'(pkt_o.reg_id));
      check_val("pkt_o.src_x", 32'(my_x_i), 32'(pkt_o.src_x));
      check_val("pkt_o.src_y", 32'(my_y_i), 32'(pkt_o.src_y));
    end
  endtask

  // sends n packets back to back
  task automatic send_reqs(input int n);
    @(negedge clk_i);
    drive_req(req_tab[1]);
    repeat (n) @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  // network side holds the return until the buffer takes it
  task automatic push_return(input tile_net_pkg::ret_type_e t, input tile_net_pkg::reg_id_t rid,
                             input tile_net_pkg::data_t d);
    @(negedge clk_i);
    ret_v_i = 1'b1;
    ret_type_i = t;
    ret_reg_id_i = rid;
    ret_data_i = d;
    wait_for(SEL_RET_READY, "ret_ready_o");
    @(negedge clk_i);
    ret_v_i = 1'b0;
  endtask

  task automatic drain_return(input int k);
    ret_row_t r;
    logic exp_force;
    r = ret_tab[k];
    exp_force = !r.yumi;
    if (r.rtype == tile_net_pkg::e_ret_ifetch) begin
      wait_for(SEL_IFETCH, "ifetch_v_o");
      check_val("ifetch_instr_o", r.data, ifetch_instr_o);
    end else if (r.rtype == tile_net_pkg::e_ret_int_wb) begin
      wait_for(SEL_INT, "int_v_o");
      check_val("int_rd_o", 32'(r.rid), 32'(int_rd_o));
      check_val("int_data_o", r.data, int_data_o);
      check_val("int_force_o", 32'(exp_force), 32'(int_force_o));
      check_val("ret_ready_o", 32'(!exp_force), 32'(ret_ready_o));
      @(negedge clk_i);
      int_yumi_i = r.yumi;
    end else begin
      wait_for(SEL_FLOAT, "float_v_o");
      check_val("float_rd_o", 32'(r.rid), 32'(float_rd_o));
      check_val("float_data_o", r.data, float_data_o);
      check_val("float_force_o", 32'(exp_force), 32'(float_force_o));
      check_val("ret_ready_o", 32'(!exp_force), 32'(ret_ready_o));
      @(negedge clk_i);
      float_yumi_i = r.yumi;
    end
    @(negedge clk_i);
    int_yumi_i = 1'b0;
    float_yumi_i = 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("test %s %s, %0d errors so far", name, (errors == test_err) ? "ok" : "failed",
             errors);
    test_err = errors;
  endtask

  initial begin
    seed = 32'h1ae7_4136;
    errors = 0;
    checks = 0;
    test_err = 0;
    hung = 1'b0;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    my_x_i = 4'd1;
    my_y_i = 4'd2;
    tgo_x_i = 4'd0;
    tgo_y_i = 4'd0;
    dram_enable_i = 1'b0;
    req_i = '0;
    req_v_i = 1'b0;
    ret_v_i = 1'b0;
    ret_type_i = tile_net_pkg::e_ret_int_wb;
    ret_reg_id_i = '0;
    ret_data_i = '0;
    int_yumi_i = 1'b0;
    float_yumi_i = 1'b0;
    fill_tables();

    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    #5;
    check_val("pkt_v_o", 0, 32'(pkt_v_o));
    check_val("invalid_eva_o", 0, 32'(invalid_eva_o));
    check_val("ifetch_v_o", 0, 32'(ifetch_v_o));
    check_val("int_v_o", 0, 32'(int_v_o));
    check_val("float_v_o", 0, 32'(float_v_o));
    check_val("int_force_o", 0, 32'(int_force_o));
    check_val("float_force_o", 0, 32'(float_force_o));
    check_val("ret_ready_o", 1, 32'(ret_ready_o));
    check_val("credits_o", `TN_MAX_CREDITS, 32'(credits_o));
    @(negedge clk_i);
    end_test("reset");

    for (i = 0; i < N_REQ; i++) begin
      wait_for(SEL_REQ_READY, "req_ready_o");
      @(negedge clk_i);
      drive_req(req_tab[i]);
      #5;
      check_packet(req_tab[i]);
      @(negedge clk_i);
      req_v_i = 1'b0;
      if (!req_tab[i].inv) begin
        check_val("credits_o", `TN_MAX_CREDITS - 1, 32'(credits_o));
        push_return(tile_net_pkg::e_ret_ifetch, req_tab[i].rid, req_tab[i].data);
      end
      check_val("credits_o", `TN_MAX_CREDITS, 32'(credits_o));
    end
    end_test("requests");

    send_reqs(`TN_MAX_CREDITS);
    req_v_i = 1'b1;
    #5;
    check_val("credits_o", 0, 32'(credits_o));
    check_val("req_ready_o", 0, 32'(req_ready_o));
    check_val("pkt_v_o", 0, 32'(pkt_v_o));
    @(negedge clk_i);
    req_v_i = 1'b0;
    push_return(tile_net_pkg::e_ret_ifetch, 5'd0, 32'h0);
    check_val("credits_o", 1, 32'(credits_o));
    check_val("req_ready_o", 1, 32'(req_ready_o));
    // spend and refund in one cycle
    req_v_i = 1'b1;
    ret_v_i = 1'b1;
    ret_type_i = tile_net_pkg::e_ret_ifetch;
    @(negedge clk_i);
    req_v_i = 1'b0;
    ret_v_i = 1'b0;
    check_val("credits_o", 1, 32'(credits_o));
    repeat (`TN_MAX_CREDITS - 1) push_return(tile_net_pkg::e_ret_ifetch, 5'd0, 32'h0);
    check_val("credits_o", `TN_MAX_CREDITS, 32'(credits_o));
    end_test("credits");

    send_reqs(3);
    for (i = 0; i < 3; i++) push_return(ret_tab[i].rtype, ret_tab[i].rid, ret_tab[i].data);
    for (i = 0; i < 3; i++) drain_return(i);
    end_test("steering");

    send_reqs(`TN_MAX_CREDITS);
    for (i = 3; i < N_RET; i++) push_return(ret_tab[i].rtype, ret_tab[i].rid, ret_tab[i].data);
    for (i = 3; i < N_RET; i++) drain_return(i);
    check_val("credits_o", `TN_MAX_CREDITS, 32'(credits_o));
    end_test("full");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== src/tile_net_top.sv ====
/*
 * Tile network endpoint
 * Request packet builder, outgoing credit counter, return buffer
 * and return steering for one compute tile.
 */

`timescale 1ns/1ps

module tile_net_top (
  input logic clk_i,
  input logic rst_n_i,
  input tile_net_pkg::x_cord_t my_x_i,
  input tile_net_pkg::y_cord_t my_y_i,
  input tile_net_pkg::x_cord_t tgo_x_i,
  input tile_net_pkg::y_cord_t tgo_y_i,
  input logic dram_enable_i,
  input tile_net_pkg::remote_req_t req_i,
  input logic req_v_i,
  output logic req_ready_o,
  output tile_net_pkg::net_packet_t pkt_o,
  output logic pkt_v_o,
  output logic invalid_eva_o,
  input logic ret_v_i,
  input tile_net_pkg::ret_type_e ret_type_i,
  input tile_net_pkg::reg_id_t ret_reg_id_i,
  input tile_net_pkg::data_t ret_data_i,
  output logic ret_ready_o,
  output logic ifetch_v_o,
  output tile_net_pkg::data_t ifetch_instr_o,
  output logic int_v_o,
  output tile_net_pkg::reg_id_t int_rd_o,
  output tile_net_pkg::data_t int_data_o,
  output logic int_force_o,
  input logic int_yumi_i,
  output logic float_v_o,
  output tile_net_pkg::reg_id_t float_rd_o,
  output tile_net_pkg::data_t float_data_o,
  output logic float_force_o,
  input logic float_yumi_i,
  output tile_net_pkg::credit_cnt_t credits_o
);

  logic credit_avail;
  logic ret_accept;

  return_if ret_bus ();

  network_tx i_network_tx (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .my_x_i(my_x_i),
    .my_y_i(my_y_i),
    .tgo_x_i(tgo_x_i),
    .tgo_y_i(tgo_y_i),
    .dram_enable_i(dram_enable_i),
    .req_i(req_i),
    .req_v_i(req_v_i),
    .credit_avail_i(credit_avail),
    .req_ready_o(req_ready_o),
    .pkt_o(pkt_o),
    .pkt_v_o(pkt_v_o),
    .invalid_eva_o(invalid_eva_o),
    .ret(ret_bus.consumer),
    .ifetch_v_o(ifetch_v_o),
    .ifetch_instr_o(ifetch_instr_o),
    .int_v_o(int_v_o),
    .int_rd_o(int_rd_o),
    .int_data_o(int_data_o),
    .int_force_o(int_force_o),
    .int_yumi_i(int_yumi_i),
    .float_v_o(float_v_o),
    .float_rd_o(float_rd_o),
    .float_data_o(float_data_o),
    .float_force_o(float_force_o),
    .float_yumi_i(float_yumi_i)
  );

  return_fifo i_return_fifo (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .ret_v_i(ret_v_i),
    .ret_type_i(ret_type_i),
    .ret_reg_id_i(ret_reg_id_i),
    .ret_data_i(ret_data_i),
    .ret_ready_o(ret_ready_o),
    .accept_o(ret_accept),
    .ret(ret_bus.producer)
  );

  // every sent packet spends a credit, every accepted return refunds one
  out_credit_counter i_out_credit_counter (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .spend_i(pkt_v_o),
    .refund_i(ret_accept),
    .credit_avail_o(credit_avail),
    .credits_o(credits_o)
  );

endmodule

// ==== src/out_credit_counter.sv ====
/*
 * Outgoing credit counter
 * Tracks free request credits; a sent packet spends one and an
 * accepted return gives one back.
 */

`timescale 1ns/1ps

`include "tile_net_defs.svh"

module out_credit_counter (
  input logic clk_i,
  input logic rst_n_i,
  input logic spend_i,
  input logic refund_i,
  output logic credit_avail_o,
  output tile_net_pkg::credit_cnt_t credits_o
);

  tile_net_pkg::credit_cnt_t count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= tile_net_pkg::credit_cnt_t'(`TN_MAX_CREDITS);
    end else begin
      case ({spend_i, refund_i})
        2'b10: count_q <= count_q - 1'b1;
        2'b01: count_q <= count_q + 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign credits_o = count_q;
  // nothing may be sent once the count hits zero
  assign credit_avail_o = (count_q != '0);

endmodule

// ==== src/return_fifo.sv ====
/*
 * Return buffer
 * Circular buffer of return entries from the network; the head
 * entry is offered to the steering logic and popped on yumi.
 */

`timescale 1ns/1ps

`include "tile_net_defs.svh"

module return_fifo (
  input logic clk_i,
  input logic rst_n_i,
  input logic ret_v_i,
  input tile_net_pkg::ret_type_e ret_type_i,
  input tile_net_pkg::reg_id_t ret_reg_id_i,
  input tile_net_pkg::data_t ret_data_i,
  output logic ret_ready_o,
  output logic accept_o,
  return_if.producer ret
);

  localparam int unsigned PTR_W = $clog2(`TN_RET_DEPTH);
  localparam int unsigned CNT_W = $clog2(`TN_RET_DEPTH + 1);

  tile_net_pkg::ret_entry_t mem_q [`TN_RET_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic full;
  logic empty;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`TN_RET_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count_q == CNT_W'(`TN_RET_DEPTH));
  assign empty = (count_q == '0);
  assign push = ret_v_i & ~full;
  assign pop = ret.yumi & ~empty;

  assign ret_ready_o = ~full;
  assign accept_o = push;
  assign ret.v = ~empty;
  assign ret.full = full;
  assign ret.entry = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= '{ret_type: ret_type_i, reg_id: ret_reg_id_i, data: ret_data_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== src/network_tx.sv ====
/*
 * Network transmit and return steering
 * Builds outgoing request packets from core requests and routes
 * buffered return entries to the ifetch, int and float ports.
 */

`timescale 1ns/1ps

module network_tx (
  input logic clk_i,
  input logic rst_n_i,
  input tile_net_pkg::x_cord_t my_x_i,
  input tile_net_pkg::y_cord_t my_y_i,
  input tile_net_pkg::x_cord_t tgo_x_i,
  input tile_net_pkg::y_cord_t tgo_y_i,
  input logic dram_enable_i,
  input tile_net_pkg::remote_req_t req_i,
  input logic req_v_i,
  input logic credit_avail_i,
  output logic req_ready_o,
  output tile_net_pkg::net_packet_t pkt_o,
  output logic pkt_v_o,
  output logic invalid_eva_o,
  return_if.consumer ret,
  output logic ifetch_v_o,
  output tile_net_pkg::data_t ifetch_instr_o,
  output logic int_v_o,
  output tile_net_pkg::reg_id_t int_rd_o,
  output tile_net_pkg::data_t int_data_o,
  output logic int_force_o,
  input logic int_yumi_i,
  output logic float_v_o,
  output tile_net_pkg::reg_id_t float_rd_o,
  output tile_net_pkg::data_t float_data_o,
  output logic float_force_o,
  input logic float_yumi_i
);

  tile_net_pkg::x_cord_t dest_x;
  tile_net_pkg::y_cord_t dest_y;
  tile_net_pkg::npa_addr_t dest_addr;
  logic addr_invalid;

  eva_to_npa i_eva_to_npa (
    .eva_i(req_i.addr),
    .dram_enable_i(dram_enable_i),
    .tgo_x_i(tgo_x_i),
    .tgo_y_i(tgo_y_i),
    .my_x_i(my_x_i),
    .my_y_i(my_y_i),
    .x_cord_o(dest_x),
    .y_cord_o(dest_y),
    .addr_o(dest_addr),
    .is_invalid_o(addr_invalid)
  );

  // packet fields
  always_comb begin
    pkt_o.op = req_i.is_amo ? tile_net_pkg::e_remote_amo
             : (req_i.write_not_read ? tile_net_pkg::e_remote_store
                                     : tile_net_pkg::e_remote_load);
    pkt_o.op_ex = req_i.is_amo ? req_i.amo_type : req_i.mask;
    pkt_o.addr = dest_addr;
    // loads carry only the destination register
    pkt_o.payload = (req_i.write_not_read | req_i.is_amo)
                  ? req_i.data
                  : tile_net_pkg::data_t'(req_i.reg_id);
    pkt_o.reg_id = req_i.reg_id;
    pkt_o.dest_x = dest_x;
    pkt_o.dest_y = dest_y;
    pkt_o.src_x = my_x_i;
    pkt_o.src_y = my_y_i;
  end

  assign req_ready_o = credit_avail_i;
  assign pkt_v_o = req_v_i & credit_avail_i & ~addr_invalid;
  assign invalid_eva_o = req_v_i & addr_invalid;

  assign ifetch_instr_o = ret.entry.data;
  assign int_rd_o = ret.entry.reg_id;
  assign int_data_o = ret.entry.data;
  assign float_rd_o = ret.entry.reg_id;
  assign float_data_o = ret.entry.data;

  // steer the head entry by type
  always_comb begin
    ifetch_v_o = 1'b0;
    int_v_o = 1'b0;
    int_force_o = 1'b0;
    float_v_o = 1'b0;
    float_force_o = 1'b0;
    ret.yumi = 1'b0;

    case (ret.entry.ret_type)
      tile_net_pkg::e_ret_ifetch: begin
        ifetch_v_o = ret.v;
        ret.yumi = ret.v;
      end
      tile_net_pkg::e_ret_float_wb: begin
        float_v_o = ret.v;
        float_force_o = ret.v & ret.full;
        ret.yumi = ret.v & (float_yumi_i | ret.full);
      end
      default: begin
        int_v_o = ret.v;
        int_force_o = ret.v & ret.full;
        ret.yumi = ret.v & (int_yumi_i | ret.full);
      end
    endcase
  end

endmodule

// ==== src/eva_to_npa.sv ====
/*
 * EVA to network address translation
 * Maps an effective virtual address to a destination tile and a word
 * address inside it, and flags addresses outside the map.
 */

`timescale 1ns/1ps

`include "tile_net_defs.svh"

module eva_to_npa (
  input tile_net_pkg::eva_t eva_i,
  input logic dram_enable_i,
  input tile_net_pkg::x_cord_t tgo_x_i,
  input tile_net_pkg::y_cord_t tgo_y_i,
  input tile_net_pkg::x_cord_t my_x_i,
  input tile_net_pkg::y_cord_t my_y_i,
  output tile_net_pkg::x_cord_t x_cord_o,
  output tile_net_pkg::y_cord_t y_cord_o,
  output tile_net_pkg::npa_addr_t addr_o,
  output logic is_invalid_o
);

  localparam int unsigned DRAM_X_W = $clog2(`TN_TILES_X);

  logic is_dram;
  logic is_global;
  tile_net_pkg::x_cord_t global_x;
  tile_net_pkg::y_cord_t global_y;

  // region select from the top two bits
  assign is_dram = eva_i[31];
  assign is_global = (eva_i[31:30] == 2'b01);

  assign global_x = eva_i[29:26];
  assign global_y = eva_i[25:22];

  // same word address field in every region
  assign addr_o = eva_i[`TN_ADDR_W+1:2];

  always_comb begin
    x_cord_o = my_x_i;
    y_cord_o = my_y_i;
    is_invalid_o = 1'b0;

    if (is_dram) begin
      // words striped across the cache row below the mesh
      x_cord_o = tile_net_pkg::x_cord_t'(eva_i[2 +: DRAM_X_W]);
      y_cord_o = tile_net_pkg::y_cord_t'(`TN_TILES_Y);
      is_invalid_o = ~dram_enable_i;
    end else if (is_global) begin
      x_cord_o = global_x;
      y_cord_o = global_y;
      is_invalid_o = (global_x >= `TN_TILES_X) || (global_y >= `TN_TILES_Y);
    end else begin
      // local, unused middle bits must be clear
      is_invalid_o = |eva_i[29:18];
    end
  end

endmodule

// ==== src/return_if.sv ====
/*
 * Return entry bus
 * Head entry of the return buffer with its valid, the buffer full
 * flag and the pop strobe from the steering logic.
 */

`timescale 1ns/1ps

interface return_if;

  logic v;
  tile_net_pkg::ret_entry_t entry;
  logic full;
  // pop, only while v is high
  logic yumi;

  modport producer (
    output v,
    output entry,
    output full,
    input yumi
  );

  modport consumer (
    input v,
    input entry,
    input full,
    output yumi
  );

endinterface

// ==== src/tile_net_pkg.sv ====
/*
 * Tile network endpoint types
 * Vector typedefs, opcodes, return types and the request, packet
 * and return-entry structs shared by the endpoint blocks.
 */

`include "tile_net_defs.svh"

package tile_net_pkg;

  typedef logic [`TN_DATA_W-1:0] data_t;
  typedef logic [31:0] eva_t;
  typedef logic [`TN_ADDR_W-1:0] npa_addr_t;
  typedef logic [`TN_X_W-1:0] x_cord_t;
  typedef logic [`TN_Y_W-1:0] y_cord_t;
  typedef logic [`TN_REG_W-1:0] reg_id_t;
  typedef logic [$clog2(`TN_MAX_CREDITS + 1)-1:0] credit_cnt_t;

  typedef enum logic [1:0] {
    e_remote_load,
    e_remote_store,
    e_remote_amo
  } net_op_e;

  typedef enum logic [1:0] {
    e_ret_int_wb,
    e_ret_float_wb,
    e_ret_ifetch
  } ret_type_e;

  // request as issued by the core
  typedef struct packed {
    eva_t addr;
    data_t data;
    logic [3:0] mask;
    reg_id_t reg_id;
    logic write_not_read;
    logic is_amo;
    logic [3:0] amo_type;
  } remote_req_t;

  typedef struct packed {
    net_op_e op;
    logic [3:0] op_ex;
    npa_addr_t addr;
    data_t payload;
    reg_id_t reg_id;
    x_cord_t dest_x;
    y_cord_t dest_y;
    x_cord_t src_x;
    y_cord_t src_y;
  } net_packet_t;

  typedef struct packed {
    ret_type_e ret_type;
    reg_id_t reg_id;
    data_t data;
  } ret_entry_t;

endpackage

// ==== include/tile_net_defs.svh ====
/*
 * Tile network endpoint parameters
 * Widths, mesh size, return buffer depth and the outgoing credit limit.
 */

`ifndef TILE_NET_DEFS_SVH
`define TILE_NET_DEFS_SVH

// data and in-tile word address
`define TN_DATA_W 32
`define TN_ADDR_W 16

// mesh coordinates
`define TN_X_W 4
`define TN_Y_W 4

// tiles per row and per column, cache row sits at y == TN_TILES_Y
`define TN_TILES_X 4
`define TN_TILES_Y 4

// return buffer entries
`define TN_RET_DEPTH 4

// requests allowed in flight
`define TN_MAX_CREDITS 4

// register file index
`define TN_REG_W 5

`endif
